// File: source/udp_echo_pkg.sv
`default_nettype none

package udp_echo_pkg;

    // frame layout: 14 ethernet + 20 ipv4 + 8 udp
    localparam int hdr_len = 42;
    localparam int len_w = 11;

    localparam logic [15:0] ethertype_ipv4 = 16'h0800;
    localparam logic [7:0] ip_ver_ihl = 8'h45;
    localparam logic [7:0] proto_udp = 8'd17;

    // byte offsets counted from the destination mac
    localparam int off_dst_mac = 0;
    localparam int off_src_mac = 6;
    localparam int off_ethertype = 12;
    localparam int off_ver_ihl = 14;
    localparam int off_proto = 23;
    localparam int off_src_ip = 26;
    localparam int off_dst_ip = 30;
    localparam int off_src_port = 34;
    localparam int off_dst_port = 36;
    localparam int off_udp_len = 38;

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_payload,
        st_drain,
        st_drop
    } rx_state_t;

endpackage

`default_nettype wire

// File: source/udp_rx_parser.sv
`timescale 1ns/10ps
`default_nettype none

module udp_rx_parser #(
    parameter logic [47:0] local_mac = 48'h0,
    parameter logic [31:0] local_ip = 32'h0,
    parameter logic [15:0] local_port = 16'h0
) (
    input  wire                              sysc,
    input  wire                              rst,
    input  wire                              rx_valid,
    input  wire [7:0]                        rx_data,
    input  wire                              rx_last,
    input  wire [udp_echo_pkg::len_w-1:0]    free_count,
    input  wire                              busy,
    output logic                             wr_en,
    output logic [7:0]                       wr_data,
    output logic                             commit,
    output logic                             rollback,
    output logic                             req_valid,
    output logic [47:0]                      req_mac,
    output logic [31:0]                      req_ip,
    output logic [15:0]                      req_port,
    output logic [udp_echo_pkg::len_w-1:0]   req_len
);
    import udp_echo_pkg::*;

    rx_state_t state;
    logic [len_w-1:0] cnt;
    logic [len_w-1:0] rem;
    logic [15:0] udp_len;
    logic [15:0] pay_len;
    logic hdr_ok;
    logic uc_ok;
    logic bc_ok;
    logic in_hdr;
    logic hdr_done;
    logic accept;
    logic is_mac;
    logic is_chk;
    logic [7:0] exp_byte;

    assign in_hdr = rx_valid && (state == st_idle || state == st_header);
    assign hdr_done = in_hdr && cnt == len_w'(hdr_len - 1);
    assign pay_len = udp_len - 16'd8;
    // all checks are settled by the last header byte
    assign accept = hdr_ok && (uc_ok || bc_ok) && !busy && udp_len >= 16'd8 &&
                    pay_len <= 16'(free_count);

    // expected value of the header byte at the current offset
    always_comb begin
        exp_byte = 8'h00;
        is_mac = 1'b0;
        is_chk = 1'b0;
        for (int i = 0; i < 6; i++) begin
            if (cnt == len_w'(off_dst_mac + i)) begin
                exp_byte = local_mac[8*(5-i) +: 8];
                is_mac = 1'b1;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (cnt == len_w'(off_dst_ip + i)) begin
                exp_byte = local_ip[8*(3-i) +: 8];
                is_chk = 1'b1;
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (cnt == len_w'(off_ethertype + i)) begin
                exp_byte = ethertype_ipv4[8*(1-i) +: 8];
                is_chk = 1'b1;
            end
            if (cnt == len_w'(off_dst_port + i)) begin
                exp_byte = local_port[8*(1-i) +: 8];
                is_chk = 1'b1;
            end
        end
        if (cnt == len_w'(off_ver_ihl)) begin
            exp_byte = ip_ver_ihl;
            is_chk = 1'b1;
        end
        if (cnt == len_w'(off_proto)) begin
            exp_byte = proto_udp;
            is_chk = 1'b1;
        end
    end

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            cnt <= '0;
            rem <= '0;
            hdr_ok <= 1'b0;
            uc_ok <= 1'b0;
            bc_ok <= 1'b0;
            wr_en <= 1'b0;
            commit <= 1'b0;
            rollback <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            commit <= 1'b0;
            rollback <= 1'b0;
            req_valid <= 1'b0;
            case (state)
                st_idle, st_header: begin
                    if (rx_valid) begin
                        cnt <= cnt + 1'b1;
                        state <= st_header;
                        // byte 0 opens a new frame
                        if (state == st_idle) begin
                            hdr_ok <= 1'b1;
                        end else if (is_chk && rx_data != exp_byte) begin
                            hdr_ok <= 1'b0;
                        end
                        if (is_mac) begin
                            uc_ok <= (state == st_idle || uc_ok) && rx_data == exp_byte;
                            bc_ok <= (state == st_idle || bc_ok) && rx_data == 8'hff;
                        end
                        if (hdr_done) begin
                            cnt <= '0;
                            if (!accept) begin
                                state <= rx_last ? st_idle : st_drop;
                            end else if (pay_len == 16'd0) begin
                                commit <= rx_last;
                                req_valid <= rx_last;
                                state <= rx_last ? st_idle : st_drain;
                            end else if (rx_last) begin
                                // payload promised but frame ended
                                rollback <= 1'b1;
                                state <= st_idle;
                            end else begin
                                rem <= pay_len[len_w-1:0];
                                state <= st_payload;
                            end
                        end else if (rx_last) begin
                            cnt <= '0;
                            state <= st_idle;
                        end
                    end
                end
                st_payload: begin
                    if (rx_valid) begin
                        wr_en <= 1'b1;
                        rem <= rem - 1'b1;
                        if (rem == len_w'(1)) begin
                            commit <= rx_last;
                            req_valid <= rx_last;
                            state <= rx_last ? st_idle : st_drain;
                        end else if (rx_last) begin
                            rollback <= 1'b1;
                            state <= st_idle;
                        end
                    end
                end
                st_drain: begin
                    // padding after the udp payload
                    if (rx_valid && rx_last) begin
                        commit <= 1'b1;
                        req_valid <= 1'b1;
                        state <= st_idle;
                    end
                end
                st_drop: begin
                    if (rx_valid && rx_last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // requester fields shift in msb first
    always_ff @(posedge sysc) begin
        if (in_hdr) begin
            if (cnt >= off_src_mac && cnt < off_src_mac + 6) begin
                req_mac <= {req_mac[39:0], rx_data};
            end
            if (cnt >= off_src_ip && cnt < off_src_ip + 4) begin
                req_ip <= {req_ip[23:0], rx_data};
            end
            if (cnt >= off_src_port && cnt < off_src_port + 2) begin
                req_port <= {req_port[7:0], rx_data};
            end
            if (cnt >= off_udp_len && cnt < off_udp_len + 2) begin
                udp_len <= {udp_len[7:0], rx_data};
            end
        end
        if (hdr_done) begin
            req_len <= pay_len[len_w-1:0];
        end
        if (state == st_payload && rx_valid) begin
            wr_data <= rx_data;
        end
    end

endmodule

`default_nettype wire

// File: source/payload_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module payload_fifo #(
    parameter int fifo_depth = 1024
) (
    input  wire                              sysc,
    input  wire                              rst,
    input  wire                              wr_en,
    input  wire [7:0]                        wr_data,
    input  wire                              commit,
    input  wire                              rollback,
    input  wire                              rd_en,
    output logic [7:0]                       rd_data,
    output logic [udp_echo_pkg::len_w-1:0]   free_count
);
    import udp_echo_pkg::*;

    localparam int aw = $clog2(fifo_depth);

    logic [7:0] mem [0:fifo_depth-1];
    // one extra bit tells full from empty
    logic [aw:0] wr_spec;
    logic [aw:0] wr_commit;
    logic [aw:0] rd_ptr;
    logic [aw:0] used;

    // space held by a frame in progress counts as used
    assign used = wr_spec - rd_ptr;
    assign free_count = len_w'(fifo_depth) - len_w'(used);

    // first-word fall-through
    assign rd_data = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge sysc) begin
        if (wr_en) begin
            mem[wr_spec[aw-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            wr_spec <= '0;
            wr_commit <= '0;
            rd_ptr <= '0;
        end else begin
            if (rollback) begin
                wr_spec <= wr_commit;
            end else if (wr_en) begin
                wr_spec <= wr_spec + 1'b1;
            end
            // last payload byte may land together with commit
            if (commit) begin
                wr_commit <= wr_en ? wr_spec + 1'b1 : wr_spec;
            end
            // reader stops at the committed point
            if (rd_en && rd_ptr != wr_commit) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/udp_tx_builder.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_builder #(
    parameter logic [47:0] local_mac = 48'h0,
    parameter logic [31:0] local_ip = 32'h0,
    parameter logic [15:0] local_port = 16'h0,
    parameter logic [7:0] ip_ttl = 8'd64
) (
    input  wire                              sysc,
    input  wire                              rst,
    input  wire                              req_valid,
    input  wire [47:0]                       req_mac,
    input  wire [31:0]                       req_ip,
    input  wire [15:0]                       req_port,
    input  wire [udp_echo_pkg::len_w-1:0]    req_len,
    input  wire [7:0]                        rd_data,
    input  wire                              tx_ready,
    output logic                             busy,
    output logic                             rd_en,
    output logic                             tx_valid,
    output logic [7:0]                       tx_data,
    output logic                             tx_last
);
    import udp_echo_pkg::*;

    logic active;
    logic xfer;
    logic in_hdr;
    logic [len_w-1:0] idx;
    logic [len_w-1:0] last_idx;

    // latched request
    logic [47:0] r_mac;
    logic [31:0] r_ip;
    logic [15:0] r_port;
    logic [len_w-1:0] r_len;

    logic [15:0] ip_total;
    logic [15:0] udp_total;
    logic [31:0] csum_sum;
    logic [16:0] csum_fold;
    logic [15:0] csum;
    logic [8*hdr_len-1:0] hdr;
    logic [8*hdr_len-1:0] hdr_shift;

    assign busy = active;
    assign tx_valid = active;
    assign xfer = active && tx_ready;
    assign in_hdr = idx < hdr_len;
    assign rd_en = xfer && !in_hdr;
    assign last_idx = len_w'(hdr_len - 1) + r_len;
    assign tx_last = active && idx == last_idx;

    assign ip_total = 16'(r_len) + 16'd28;
    assign udp_total = 16'(r_len) + 16'd8;

    // ipv4 header checksum, checksum word counted as zero
    assign csum_sum = {ip_ver_ihl, 8'h00} + ip_total + 16'h0000 + 16'h4000 +
                      {ip_ttl, proto_udp} + local_ip[31:16] + local_ip[15:0] +
                      r_ip[31:16] + r_ip[15:0];
    assign csum_fold = csum_sum[15:0] + csum_sum[31:16];
    assign csum = ~(csum_fold[15:0] + 16'(csum_fold[16]));

    // whole reply header, first byte in the top bits
    assign hdr = {
        r_mac, local_mac, ethertype_ipv4,
        ip_ver_ihl, 8'h00, ip_total,
        16'h0000, 16'h4000,
        ip_ttl, proto_udp, csum,
        local_ip, r_ip,
        local_port, r_port, udp_total, 16'h0000
    };
    assign hdr_shift = hdr << (idx * 8);

    // payload comes straight from the fifo head
    assign tx_data = in_hdr ? hdr_shift[8*hdr_len-1 -: 8] : rd_data;

    always_ff @(posedge sysc or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            idx <= '0;
        end else if (!active) begin
            if (req_valid) begin
                active <= 1'b1;
                idx <= '0;
            end
        end else if (xfer) begin
            if (idx == last_idx) begin
                active <= 1'b0;
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge sysc) begin
        if (req_valid && !active) begin
            r_mac <= req_mac;
            r_ip <= req_ip;
            r_port <= req_port;
            r_len <= req_len;
        end
    end

endmodule

`default_nettype wire

// File: source/udp_echo_top.sv
`timescale 1ns/10ps
`default_nettype none

module udp_echo_top #(
    parameter logic [47:0] local_mac = 48'h00_0a_35_01_fe_c0,
    parameter logic [31:0] local_ip = 32'hc0_a8_00_02,
    parameter logic [15:0] local_port = 16'd8080,
    parameter logic [7:0] ip_ttl = 8'd64,
    parameter int fifo_depth = 1024
) (
    input  wire         sysc,
    input  wire         rst,
    input  wire         rx_valid,
    input  wire [7:0]   rx_data,
    input  wire         rx_last,
    input  wire         tx_ready,
    output logic        tx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_last
);
    import udp_echo_pkg::*;

    // parser to fifo
    logic wr_en;
    logic [7:0] wr_data;
    logic commit;
    logic rollback;
    logic [len_w-1:0] free_count;

    // parser to builder
    logic req_valid;
    logic [47:0] req_mac;
    logic [31:0] req_ip;
    logic [15:0] req_port;
    logic [len_w-1:0] req_len;
    logic busy;

    // builder to fifo
    logic rd_en;
    logic [7:0] rd_data;

    udp_rx_parser #(
        .local_mac(local_mac),
        .local_ip(local_ip),
        .local_port(local_port)
    ) udp_rx_parser_inst (
        .sysc(sysc),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_last(rx_last),
        .free_count(free_count),
        .busy(busy),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .commit(commit),
        .rollback(rollback),
        .req_valid(req_valid),
        .req_mac(req_mac),
        .req_ip(req_ip),
        .req_port(req_port),
        .req_len(req_len)
    );

    payload_fifo #(
        .fifo_depth(fifo_depth)
    ) payload_fifo_inst (
        .sysc(sysc),
        .rst(rst),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .commit(commit),
        .rollback(rollback),
        .rd_en(rd_en),
        .rd_data(rd_data),
        .free_count(free_count)
    );

    udp_tx_builder #(
        .local_mac(local_mac),
        .local_ip(local_ip),
        .local_port(local_port),
        .ip_ttl(ip_ttl)
    ) udp_tx_builder_inst (
        .sysc(sysc),
        .rst(rst),
        .req_valid(req_valid),
        .req_mac(req_mac),
        .req_ip(req_ip),
        .req_port(req_port),
        .req_len(req_len),
        .rd_data(rd_data),
        .tx_ready(tx_ready),
        .busy(busy),
        .rd_en(rd_en),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_last(tx_last)
    );

endmodule

`default_nettype wire

// File: verification/udp_frame_model.svh
`ifndef udp_frame_model_svh
`define udp_frame_model_svh

// source fields differ per row so every reply is distinct
function automatic logic [47:0] src_mac_of(input int row);
    return {40'h02_11_22_33_44, 8'(row)};
endfunction

function automatic logic [31:0] src_ip_of(input int row);
    return {24'h0a_00_01, 8'(row + 10)};
endfunction

function automatic logic [15:0] src_port_of(input int row);
    return 16'(40000 + row);
endfunction

function automatic logic [7:0] payload_byte(input int row, input int i);
    return 8'(row * 29 + i * 7 + 17);
endfunction

// append n bytes of v, most significant first
task automatic put_field(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) begin
        work_q.push_back(v[8*i +: 8]);
    end
endtask

task automatic build_request(input int row);
    int n;
    logic [15:0] plen;
    plen = 16'(tests[row].pay_len);
    // truncated rows stop halfway through the payload
    n = tests[row].trunc ? int'(plen) / 2 : int'(plen);
    work_q.delete();
    put_field(tests[row].dst_mac, 6);
    put_field(src_mac_of(row), 6);
    put_field(48'h0800, 2);
    put_field(48'h4500, 2);
    put_field(48'(plen + 16'd28), 2);
    put_field(48'h0000_4000, 4);
    put_field(48'({tb_ttl, tests[row].proto}), 2);
    put_field(48'h0, 2);
    put_field(48'(src_ip_of(row)), 4);
    put_field(48'(tests[row].dst_ip), 4);
    put_field(48'(src_port_of(row)), 2);
    put_field(48'(tests[row].dst_port), 2);
    put_field(48'(plen + 16'd8), 2);
    put_field(48'h0, 2);
    for (int i = 0; i < n; i++) begin
        work_q.push_back(payload_byte(row, i));
    end
    frame_q = work_q;
endtask

task automatic build_reply(input int row);
    int unsigned sum;
    logic [15:0] csum;
    logic [15:0] plen;
    plen = 16'(tests[row].pay_len);
    work_q.delete();
    put_field(src_mac_of(row), 6);
    put_field(tb_mac, 6);
    put_field(48'h0800, 2);
    put_field(48'h4500, 2);
    put_field(48'(plen + 16'd28), 2);
    put_field(48'h0000_4000, 4);
    put_field(48'({tb_ttl, 8'd17}), 2);
    put_field(48'h0, 2);
    put_field(48'(tb_ip), 4);
    put_field(48'(src_ip_of(row)), 4);
    put_field(48'(tb_port), 2);
    put_field(48'(src_port_of(row)), 2);
    put_field(48'(plen + 16'd8), 2);
    put_field(48'h0, 2);
    // ten ipv4 header words, checksum word still zero
    sum = 0;
    for (int i = 14; i < 34; i += 2) begin
        sum += {16'h0, work_q[i], work_q[i + 1]};
    end
    while (sum > 32'hffff) begin
        sum = (sum & 32'hffff) + (sum >> 16);
    end
    csum = ~sum[15:0];
    work_q[24] = csum[15:8];
    work_q[25] = csum[7:0];
    for (int i = 0; i < int'(plen); i++) begin
        work_q.push_back(payload_byte(row, i));
    end
    foreach (work_q[i]) begin
        exp_bytes.push_back(work_q[i]);
    end
    exp_len.push_back(work_q.size());
    exp_row.push_back(row);
endtask

`endif

// File: verification/udp_echo_tb.sv
`timescale 1ns/10ps
`default_nettype none

module udp_echo_tb;

    localparam logic [47:0] tb_mac = 48'h00_0a_35_01_fe_c0;
    localparam logic [31:0] tb_ip = 32'hc0_a8_00_02;
    localparam logic [15:0] tb_port = 16'd8080;
    localparam logic [7:0] tb_ttl = 8'd64;
    localparam int hdr_bytes = 42;
    // longest reply at half ready rate, with margin
    localparam int reply_wait = 1200;
    localparam int n_tests = 11;

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
        logic [15:0] dst_port;
        logic [7:0] proto;
        logic [10:0] pay_len;
        logic trunc;
        logic rnd_ready;
        logic overlap;
        logic exp_reply;
    } test_row_t;

    // overlap rows are sent while the previous reply is still going out
    test_row_t tests [n_tests] = '{
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd16, 1'b0, 1'b0, 1'b0, 1'b1},
        '{48'hffff_ffff_ffff, tb_ip, tb_port, 8'd17, 11'd0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{48'h00_0a_35_01_fe_c1, tb_ip, tb_port, 8'd17, 11'd8, 1'b0, 1'b0, 1'b0, 1'b0},
        '{tb_mac, 32'hc0_a8_00_03, tb_port, 8'd17, 11'd8, 1'b0, 1'b0, 1'b0, 1'b0},
        '{tb_mac, tb_ip, 16'd8081, 8'd17, 11'd8, 1'b0, 1'b0, 1'b0, 1'b0},
        '{tb_mac, tb_ip, tb_port, 8'd6, 11'd8, 1'b0, 1'b0, 1'b0, 1'b0},
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd40, 1'b1, 1'b0, 1'b0, 1'b0},
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd24, 1'b0, 1'b0, 1'b0, 1'b1},
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd200, 1'b0, 1'b1, 1'b0, 1'b1},
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd12, 1'b0, 1'b1, 1'b1, 1'b0},
        '{tb_mac, tb_ip, tb_port, 8'd17, 11'd5, 1'b0, 1'b0, 1'b0, 1'b1}
    };

    logic sysc;
    logic rst;
    logic rx_valid;
    logic [7:0] rx_data;
    logic rx_last;
    logic tx_ready;
    logic tx_valid;
    logic [7:0] tx_data;
    logic tx_last;

    logic rand_ready = 1'b0;
    logic [7:0] work_q[$];
    logic [7:0] frame_q[$];
    logic [7:0] got_q[$];
    logic [7:0] exp_bytes[$];
    int exp_len[$];
    int exp_row[$];
    int err_cnt = 0;
    int exp_cnt = 0;
    int done_cnt = 0;
    int extra_cnt = 0;

    `include "udp_frame_model.svh"

    udp_echo_top #(
        .local_mac(tb_mac),
        .local_ip(tb_ip),
        .local_port(tb_port),
        .ip_ttl(tb_ttl),
        .fifo_depth(1024)
    ) udp_echo_top_inst (
        .sysc(sysc),
        .rst(rst),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_last(rx_last),
        .tx_ready(tx_ready),
        .tx_valid(tx_valid),
        .tx_data(tx_data),
        .tx_last(tx_last)
    );

    initial begin
        sysc = 1'b0;
        forever #4 sysc = ~sysc;
    end

    function automatic int watchdog_cycles();
        int total;
        total = 0;
        for (int t = 0; t < n_tests; t++) begin
            total += hdr_bytes + int'(tests[t].pay_len);
        end
        return total * 4 + 2000;
    endfunction

    task automatic send_frame();
        for (int i = 0; i < frame_q.size(); i++) begin
            @(posedge sysc);
            #1;
            rx_valid = 1'b1;
            rx_data = frame_q[i];
            rx_last = (i == frame_q.size() - 1);
        end
        @(posedge sysc);
        #1;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        rx_last = 1'b0;
        repeat (2) @(posedge sysc);
    endtask

    task automatic wait_replies(input int limit);
        int waited;
        waited = 0;
        while (done_cnt < exp_cnt && waited < limit) begin
            @(posedge sysc);
            waited++;
        end
        if (done_cnt < exp_cnt) begin
            $display("reply missing: only %0d of %0d replies arrived", done_cnt, exp_cnt);
            err_cnt++;
        end
    endtask

    task automatic check_reply();
        int len;
        int row;
        int bad;
        logic [7:0] e;
        if (exp_len.size() == 0) begin
            $display("unexpected reply of %0d bytes at %0t", got_q.size(), $time);
            extra_cnt++;
            err_cnt++;
        end else begin
            len = exp_len.pop_front();
            row = exp_row.pop_front();
            bad = 0;
            if (got_q.size() != len) begin
                $display("test %0d: reply has %0d bytes instead of %0d", row, got_q.size(), len);
                bad++;
            end
            for (int i = 0; i < len; i++) begin
                e = exp_bytes.pop_front();
                if (i < got_q.size() && got_q[i] != e) begin
                    $display("[ERROR] %0t: test %0d byte %0d is %02h, expected %02h",
                             $time, row, i, got_q[i], e);
                    bad++;
                end
            end
            err_cnt += bad;
            done_cnt++;
            $display("test %0d: reply of %0d bytes %0s", row, len, bad == 0 ? "ok" : "wrong");
        end
    endtask

    // tx_ready changes just after the rising edge
    initial begin
        void'($urandom(18));
        tx_ready = 1'b1;
        forever begin
            @(posedge sysc);
            #1;
            if (rand_ready) begin
                tx_ready = ($urandom % 2) == 0;
            end else begin
                tx_ready = 1'b1;
            end
        end
    end

    // outputs are settled at the falling edge
    initial begin
        forever begin
            @(negedge sysc);
            if (!rst && tx_valid && tx_ready) begin
                got_q.push_back(tx_data);
                if (tx_last) begin
                    check_reply();
                    got_q.delete();
                end
            end
        end
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge sysc);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles());
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        rx_last = 1'b0;
        repeat (16) @(posedge sysc);
        #1;
        rst = 1'b0;
        @(negedge sysc);
        if (tx_valid !== 1'b0) begin
            $display("tx_valid is not low after reset");
            err_cnt++;
        end
        for (int t = 0; t < n_tests; t++) begin
            if (!tests[t].overlap) begin
                wait_replies(reply_wait);
                rand_ready = tests[t].rnd_ready;
            end
            build_request(t);
            if (tests[t].exp_reply) begin
                build_reply(t);
                exp_cnt++;
            end
            send_frame();
            if (!tests[t].exp_reply) begin
                $display("test %0d: frame sent, no reply expected", t);
            end
        end
        wait_replies(reply_wait);
        // quiet period to catch a late extra reply
        repeat (100) @(posedge sysc);
        if (got_q.size() != 0) begin
            $display("reply of %0d bytes never ended with tx_last", got_q.size());
            err_cnt++;
        end
        $display("tests %0d, replies %0d of %0d, unexpected %0d, errors %0d",
                 n_tests, done_cnt, exp_cnt, extra_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verification
source/udp_echo_pkg.sv
source/udp_rx_parser.sv
source/payload_fifo.sv
source/udp_tx_builder.sv
source/udp_echo_top.sv
verification/udp_echo_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f build.f --top-module udp_echo_tb -o udp_echo_sim \
    && ./obj_dir/udp_echo_sim | tee /dev/stderr | grep -q -x -F "** PASS **" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
